/* rtl/fetch_pkg.sv */
package fetch_pkg;

  // ##################################################
  // widths
  // ##################################################

  parameter int ADDR_W = 32;
  parameter int INST_W = 32;

  typedef logic [INST_W-1:0] inst_t;

  // ##################################################
  // controller states
  // ##################################################

  typedef enum logic [1:0] {
    LOOKUP    = 2'd0,  // cache probe, hits go straight out.
    MISS_REQ  = 2'd1,  // one-cycle bus request.
    MISS_WAIT = 2'd2,  // waiting on the memory response.
    HOLD      = 2'd3   // filled word presented until accepted.
  } fetch_state_e;

  // boot address of the core.
  parameter logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000;

endpackage

/* rtl/tagged_array.sv */
`timescale 1ns/1ps

module tagged_array #(
  parameter int  DEPTH_W = 8,
  parameter type ENTRY_T = logic [31:0]
) (
  input  logic               clk,
  input  logic               wr_en_i,
  input  logic [DEPTH_W-1:0] wr_idx_i,
  input  ENTRY_T             wr_data_i,
  input  logic [DEPTH_W-1:0] rd_idx_i,
  output ENTRY_T             rd_data_o
);

  localparam int DEPTH = 2 ** DEPTH_W;

  ENTRY_T mem [DEPTH];

  // one write port, registered.
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      mem[wr_idx_i] <= wr_data_i;
    end
  end

  // the read is combinational so a lookup resolves in the same cycle.
  assign rd_data_o = mem[rd_idx_i];

endmodule

/* rtl/icache_direct.sv */
`timescale 1ns/1ps

module icache_direct import fetch_pkg::*; #(
  parameter int INDEX_W = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] lookup_addr_i,
  output logic              hit_o,
  output inst_t             hit_inst_o,
  input  logic              fill_en_i,
  input  logic [ADDR_W-1:0] fill_addr_i,
  input  inst_t             fill_inst_i
);

  localparam int TAG_W   = ADDR_W - INDEX_W - 2;
  localparam int ENTRIES = 2 ** INDEX_W;

  // ##################################################
  // address split
  // ##################################################

  logic [INDEX_W-1:0] lookup_idx;
  logic [TAG_W-1:0]   lookup_tag;
  logic [INDEX_W-1:0] fill_idx;
  logic [TAG_W-1:0]   fill_tag;
  logic [1:0]         fill_off;
  logic [TAG_W-1:0]   stored_tag;
  logic [ENTRIES-1:0] valid_q;

  assign lookup_idx = lookup_addr_i[INDEX_W+1:2];
  assign lookup_tag = lookup_addr_i[ADDR_W-1:INDEX_W+2];
  assign fill_off   = fill_addr_i[1:0];
  assign fill_idx   = fill_addr_i[INDEX_W+1:2];
  assign fill_tag   = fill_addr_i[ADDR_W-1:INDEX_W+2];

  // ##################################################
  // storage
  // ##################################################

  tagged_array #(
    .DEPTH_W (INDEX_W),
    .ENTRY_T (logic [TAG_W-1:0])
  ) tag_array0 (
    .clk       (clk),
    .wr_en_i   (fill_en_i),
    .wr_idx_i  (fill_idx),
    .wr_data_i (fill_tag),
    .rd_idx_i  (lookup_idx),
    .rd_data_o (stored_tag)
  );

  tagged_array #(
    .DEPTH_W (INDEX_W),
    .ENTRY_T (inst_t)
  ) data_array0 (
    .clk       (clk),
    .wr_en_i   (fill_en_i),
    .wr_idx_i  (fill_idx),
    .wr_data_i (fill_inst_i),
    .rd_idx_i  (lookup_idx),
    .rd_data_o (hit_inst_o)
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (fill_en_i)
    begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // an entry only hits once it is valid and holds the same tag.
  assign hit_o = valid_q[lookup_idx] && (stored_tag == lookup_tag);

  a_fill_aligned: assert property (@(posedge clk) disable iff (rst)
    fill_en_i |-> fill_off == 2'b00);

endmodule

/* rtl/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              advance_i,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  output logic [ADDR_W-1:0] pc_o
);

  logic [ADDR_W-1:0] pc_q;

  // a redirect wins over an accepted instruction in the same cycle.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
    end
    else if (redirect_i)
    begin
      pc_q <= redirect_pc_i;
    end
    else if (advance_i)
    begin
      pc_q <= pc_q + ADDR_W'(4);  // next word.
    end
  end

  assign pc_o = pc_q;

endmodule

/* rtl/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] pc_i,
  input  logic              hit_i,
  input  inst_t             hit_inst_i,
  input  logic              redirect_i,
  input  logic              mem_rvalid_i,
  input  inst_t             mem_rdata_i,
  input  logic              inst_ready_i,
  output logic              advance_o,
  output logic              fill_en_o,
  output logic [ADDR_W-1:0] fill_addr_o,
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic              inst_valid_o,
  output inst_t             inst_o,
  output logic [ADDR_W-1:0] inst_pc_o
);

  fetch_state_e      state_q;
  fetch_state_e      state_d;
  logic              stale_q;
  logic [ADDR_W-1:0] miss_addr_q;
  inst_t             miss_inst_q;

  // ##################################################
  // state machine
  // ##################################################

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      LOOKUP:
      begin
        if (!redirect_i && !hit_i)
        begin
          state_d = MISS_REQ;
        end
      end
      MISS_REQ:
      begin
        state_d = MISS_WAIT;
      end
      MISS_WAIT:
      begin
        // a stale response still fills, but is never shown to decode.
        if (mem_rvalid_i)
        begin
          state_d = (stale_q || redirect_i) ? LOOKUP : HOLD;
        end
      end
      HOLD:
      begin
        if (redirect_i || inst_ready_i)
        begin
          state_d = LOOKUP;
        end
      end
      default: state_d = LOOKUP;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= LOOKUP;
      stale_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (redirect_i && (state_q == MISS_REQ || state_q == MISS_WAIT))
      begin
        stale_q <= 1'b1;
      end
      if (state_d == LOOKUP)
      begin
        stale_q <= 1'b0;  // cleared once the miss has drained.
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == LOOKUP)
    begin
      miss_addr_q <= pc_i;
    end
    if (state_q == MISS_WAIT && mem_rvalid_i)
    begin
      miss_inst_q <= mem_rdata_i;
    end
  end

  // ##################################################
  // outputs
  // ##################################################

  assign mem_req_o    = (state_q == MISS_REQ);
  assign mem_addr_o   = miss_addr_q;
  assign fill_en_o    = (state_q == MISS_WAIT) && mem_rvalid_i;
  assign fill_addr_o  = miss_addr_q;

  assign inst_valid_o = (state_q == LOOKUP && hit_i) || (state_q == HOLD);
  assign inst_o       = (state_q == HOLD) ? miss_inst_q : hit_inst_i;
  assign inst_pc_o    = (state_q == HOLD) ? miss_addr_q : pc_i;
  assign advance_o    = inst_valid_o && inst_ready_i;

  // a request only goes out for a pc that the cache does not hold.
  a_req_on_miss: assert property (@(posedge clk) disable iff (rst)
    mem_req_o |-> !hit_i);

  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (rst)
    mem_rvalid_i |-> !(state_q == LOOKUP || state_q == HOLD));

  // back-pressure must not disturb the presented instruction.
  a_stable_stall: assert property (@(posedge clk) disable iff (rst)
    inst_valid_o && !inst_ready_i && !redirect_i
      |=> inst_valid_o && $stable(inst_o) && $stable(inst_pc_o));

endmodule

/* rtl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter int INDEX_W = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              mem_rvalid_i,
  input  inst_t             mem_rdata_i,
  input  logic              inst_ready_i,
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output logic              inst_valid_o,
  output inst_t             inst_o,
  output logic [ADDR_W-1:0] inst_pc_o
);

  logic [ADDR_W-1:0] pc;
  logic              hit;
  inst_t             hit_inst;
  logic              advance;
  logic              fill_en;
  logic [ADDR_W-1:0] fill_addr;

  pc_gen pc_gen0 (
    .clk           (clk),
    .rst           (rst),
    .advance_i     (advance),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc)
  );

  // the fill word comes straight off the bus in the response cycle.
  icache_direct #(
    .INDEX_W (INDEX_W)
  ) icache0 (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (pc),
    .hit_o         (hit),
    .hit_inst_o    (hit_inst),
    .fill_en_i     (fill_en),
    .fill_addr_i   (fill_addr),
    .fill_inst_i   (mem_rdata_i)
  );

  fetch_ctrl ctrl0 (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc),
    .hit_i        (hit),
    .hit_inst_i   (hit_inst),
    .redirect_i   (redirect_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .inst_ready_i (inst_ready_i),
    .advance_o    (advance),
    .fill_en_o    (fill_en),
    .fill_addr_o  (fill_addr),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o)
  );

endmodule

/* bench/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*;;

  localparam int TB_INDEX_W = 4;
  localparam int WAIT_LIMIT = 1000;

  logic              clk = 1'b0;
  logic              rst;
  logic              redirect_i;
  logic [ADDR_W-1:0] redirect_pc_i;
  logic              mem_rvalid_i = 1'b0;
  inst_t             mem_rdata_i = '0;
  logic              inst_ready_i = 1'b0;
  logic              mem_req_o;
  logic [ADDR_W-1:0] mem_addr_o;
  logic              inst_valid_o;
  inst_t             inst_o;
  logic [ADDR_W-1:0] inst_pc_o;

  logic [31:0] rng = 32'd35;
  logic        bp_mode;
  logic        req_flag = 1'b0;
  logic [31:0] req_addr = '0;
  logic        outstanding = 1'b0;
  logic        timed_out = 1'b0;
  int          lat_cnt = 0;
  int          accepted = 0;
  int          req_count = 0;
  int          value_errs = 0;
  int          other_errs = 0;
  int          start;
  logic [31:0] exp_pc = RESET_PC;
  logic [31:0] last_pc = '0;
  logic        held_valid = 1'b0;
  logic [31:0] held_inst;
  logic [31:0] held_pc;
  logic        shadow_valid [16] = '{default: 1'b0};
  logic [25:0] shadow_tag [16];

  fetch_top #(.INDEX_W(TB_INDEX_W)) dut0 (
    .clk(clk), .rst(rst), .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
    .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i), .inst_ready_i(inst_ready_i),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .inst_valid_o(inst_valid_o),
    .inst_o(inst_o), .inst_pc_o(inst_pc_o)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every address gets its own word, so a wrong fetch shows up as a wrong value.
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[7:0], addr[31:8]} ^ 32'h5A5A_0F0F;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
      value_errs++;
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
  endtask

  // ##################################################
  // memory model and ready
  // ##################################################

  always @(posedge clk)
  begin
    if (rst)
    begin
      mem_rvalid_i <= 1'b0;
      lat_cnt = 0;
    end
    else
    begin
      mem_rvalid_i <= 1'b0;
      rng = xorshift(rng);
      if (req_flag)
      begin
        lat_cnt = 1 + int'(rng % 32'd6);  // one to six cycles.
      end
      if (lat_cnt != 0)
      begin
        lat_cnt--;
        if (lat_cnt == 0)
        begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= mem_word(req_addr);
        end
      end
      inst_ready_i <= bp_mode ? (rng[9:8] != 2'b00) : 1'b1;
    end
  end

  // ##################################################
  // scoreboard, sampled at the falling edge
  // ##################################################

  always @(negedge clk)
  begin
    req_flag = mem_req_o;
    if (!rst)
    begin
      if (held_valid)
      begin
        check_value("inst_valid_o (stall)", 32'd1, 32'(inst_valid_o));
        check_value("inst_o (stall)", held_inst, inst_o);
        check_value("inst_pc_o (stall)", held_pc, inst_pc_o);
      end
      if (inst_valid_o)
      begin
        check_value("inst_pc_o", exp_pc, inst_pc_o);
        check_value("inst_o", mem_word(exp_pc), inst_o);
      end
      held_valid = inst_valid_o && !inst_ready_i && !redirect_i;
      held_inst  = inst_o;
      held_pc    = inst_pc_o;
      if (inst_valid_o && inst_ready_i)
      begin
        accepted++;
        last_pc = inst_pc_o;
        exp_pc  = exp_pc + 32'd4;
      end
      if (mem_rvalid_i)
      begin
        outstanding = 1'b0;
        shadow_valid[req_addr[5:2]] = 1'b1;
        shadow_tag[req_addr[5:2]]   = req_addr[31:6];
      end
      if (mem_req_o)
      begin
        if (outstanding)
        begin
          $display("%0t a second bus request was raised while one was outstanding", $time);
          other_errs++;
        end
        if (shadow_valid[mem_addr_o[5:2]] && shadow_tag[mem_addr_o[5:2]] == mem_addr_o[31:6])
        begin
          $display("%0t a bus request went out for an address that should hit", $time);
          other_errs++;
        end
        check_value("mem_addr_o", exp_pc, mem_addr_o);
        outstanding = 1'b1;
        req_addr    = mem_addr_o;
        req_count++;
      end
      if (redirect_i)
      begin
        exp_pc = redirect_pc_i;  // a redirect wins over the increment.
      end
    end
  end

  // ##################################################
  // stimulus
  // ##################################################

  task automatic note_timeout(input string what);
    $display("timeout while waiting for %s", what);
    other_errs++;
    timed_out = 1'b1;
  endtask

  task automatic wait_accepts(input int n);
    int first;
    int cycles;
    first  = accepted;
    cycles = 0;
    while (!timed_out && accepted < first + n && cycles < WAIT_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!timed_out && accepted < first + n)
    begin
      note_timeout("accepted instructions");
    end
  endtask

  task automatic wait_request();
    int first;
    int cycles;
    first  = req_count;
    cycles = 0;
    while (!timed_out && req_count == first && cycles < WAIT_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!timed_out && req_count == first)
    begin
      note_timeout("a bus request");
    end
  endtask

  task automatic redirect_to(input logic [31:0] target);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    @(posedge clk);
    redirect_i    <= 1'b0;
  endtask

  initial
  begin
    rst           = 1'b1;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    bp_mode       = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("inst_valid_o after reset", 32'd0, 32'(inst_valid_o));
    check_value("mem_req_o after reset", 32'd0, 32'(mem_req_o));
    @(posedge clk);
    wait_accepts(24);
    start = req_count;
    redirect_to(32'h0000_1040);  // lines still resident from the first pass.
    wait_accepts(8);
    check_value("bus requests on hits", 32'd0, 32'(req_count - start));
    start = req_count;
    redirect_to(32'h0000_1100);  // same indices, other tag.
    wait_accepts(2);
    check_value("bus requests on conflicts", 32'd2, 32'(req_count - start));
    start = req_count;
    redirect_to(32'h0000_1040);
    wait_accepts(1);
    check_value("bus requests after eviction", 32'd1, 32'(req_count - start));
    redirect_to(32'h0000_2000);
    wait_request();
    redirect_to(32'h0000_1044);  // lands while the miss on 0x2000 is in flight.
    wait_accepts(1);
    check_value("pc after redirect in miss", 32'h0000_1044, last_pc);
    start = req_count;
    redirect_to(32'h0000_2000);
    wait_accepts(1);
    check_value("pc of stale line", 32'h0000_2000, last_pc);
    check_value("bus requests for stale line", 32'd0, 32'(req_count - start));
    bp_mode <= 1'b1;
    redirect_to(32'h0000_1000);
    wait_accepts(40);
    bp_mode <= 1'b0;
    repeat (10) @(posedge clk);
    report_counts();
    if (value_errs == 0 && other_errs == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* fetch_top.f */
rtl/fetch_pkg.sv
rtl/tagged_array.sv
rtl/icache_direct.sv
rtl/pc_gen.sv
rtl/fetch_ctrl.sv
rtl/fetch_top.sv
bench/fetch_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = fetch_tb
FILELIST  = fetch_top.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
